// ==== logic/ialu_cfg.svh ====
// Width settings for the integer ALU, shared by the RTL and the testbench.
// Include this file wherever a data, shift or counter width is needed.

`ifndef IALU_CFG_SVH
`define IALU_CFG_SVH

// Data path width of the core
`define IALU_XLEN     32
// Shift amount taken from the low bits of op2
`define IALU_SHAMT_W  5
// Divider iteration counter, counts XLEN iterations
`define IALU_CNT_W    5

`endif

// ==== logic/ialu_pkg.sv ====
// Types for the integer ALU: command encoding, adder flags and divider FSM.
// Modules pull these in with a wildcard import in their header.

package ialu_pkg;

    // ALU commands as issued by the core decoder
    typedef enum logic [3:0] {
        CMD_AND  = 4'd0,
        CMD_OR   = 4'd1,
        CMD_XOR  = 4'd2,
        CMD_ADD  = 4'd3,
        CMD_SUB  = 4'd4,
        CMD_LT   = 4'd5,    // Signed less-than
        CMD_LTU  = 4'd6,
        CMD_EQ   = 4'd7,
        CMD_NE   = 4'd8,
        CMD_GE   = 4'd9,
        CMD_GEU  = 4'd10,
        CMD_SLL  = 4'd11,
        CMD_SRL  = 4'd12,
        CMD_SRA  = 4'd13,
        CMD_DIVU = 4'd14,   // Iterative unless an operand is zero
        CMD_REMU = 4'd15
    } ialu_cmd_e;

    // Flags of the main adder
    typedef struct packed {
        logic z;    // Zero
        logic s;    // Sign
        logic o;    // Signed overflow
        logic c;    // Carry out, borrow on subtract
    } alu_flags_s;

    typedef enum logic {
        IDLE = 1'b0,
        ITER = 1'b1
    } div_state_e;

endpackage

// ==== logic/div_if.sv ====
// Link between the ALU control and the serial divider.
// The requester holds start with stable operands; the divider pulses done.

`include "ialu_cfg.svh"

interface div_if;

    logic                  start;       // Held high while a division is wanted
    logic [`IALU_XLEN-1:0] dividend;
    logic [`IALU_XLEN-1:0] divisor;
    logic                  done;        // One-cycle pulse, results valid with it
    logic [`IALU_XLEN-1:0] quotient;
    logic [`IALU_XLEN-1:0] remainder;

    modport requester (
        output start, dividend, divisor,
        input  done, quotient, remainder
    );

    modport divider (
        input  start, dividend, divisor,
        output done, quotient, remainder
    );

endinterface

// ==== logic/alu_core.sv ====
// Combinational half of the integer ALU: command decode, adder with flags,
// shifter, logic ops and result select. Nonzero unsigned divisions are passed
// to the serial divider over div_if; zero-operand divisions finish here.

`include "ialu_cfg.svh"

module alu_core
    import ialu_pkg::*;
(
    input  logic                  in_valid,
    input  logic [`IALU_XLEN-1:0] op1,
    input  logic [`IALU_XLEN-1:0] op2,
    input  ialu_cmd_e             cmd,
    output logic                  in_ready,
    output logic                  busy,
    output logic [`IALU_XLEN-1:0] result,
    output logic                  cmp,
    div_if.requester              div_port
);

logic                     sum_sub;      // Subtract for SUB and all compares
logic                     op2_sign;     // Sign of op2 as seen by the adder
logic [`IALU_XLEN:0]      sum_res;
alu_flags_s               flags;
logic [`IALU_SHAMT_W-1:0] shamt;
logic [`IALU_XLEN-1:0]    shft_res;
logic                     is_div;
logic                     div_iter;     // Needs the serial divider
logic [`IALU_XLEN-1:0]    div_res;

//----------------------------------------------------------------------
// Adder and flags
//----------------------------------------------------------------------
assign sum_sub  = (cmd != CMD_ADD);
assign op2_sign = op2[`IALU_XLEN-1] ^ sum_sub;
assign sum_res  = sum_sub ? ({1'b0, op1} - {1'b0, op2})
                          : ({1'b0, op1} + {1'b0, op2});

always_comb begin
    flags.z = ~|sum_res[`IALU_XLEN-1:0];
    flags.s = sum_res[`IALU_XLEN-1];
    flags.c = sum_res[`IALU_XLEN];
    // Operands of equal sign giving a result of the other sign
    flags.o = (op1[`IALU_XLEN-1] == op2_sign) & (sum_res[`IALU_XLEN-1] != op1[`IALU_XLEN-1]);
end

//----------------------------------------------------------------------
// Shifter
//----------------------------------------------------------------------
assign shamt = op2[`IALU_SHAMT_W-1:0];

always_comb begin
    case (cmd)
        CMD_SRL: shft_res = op1 >> shamt;
        CMD_SRA: shft_res = $signed(op1) >>> shamt;   // Sign fill
        default: shft_res = op1 << shamt;
    endcase
end

//----------------------------------------------------------------------
// Compares
//----------------------------------------------------------------------
always_comb begin
    case (cmd)
        CMD_LT:  cmp = flags.s ^ flags.o;
        CMD_LTU: cmp = flags.c;                       // Borrow means op1 < op2
        CMD_EQ:  cmp = flags.z;
        CMD_NE:  cmp = ~flags.z;
        CMD_GE:  cmp = ~(flags.s ^ flags.o);
        CMD_GEU: cmp = ~flags.c;
        default: cmp = 1'b0;
    endcase
end

//----------------------------------------------------------------------
// Division request and early exits
//----------------------------------------------------------------------
assign is_div   = (cmd == CMD_DIVU) | (cmd == CMD_REMU);
assign div_iter = is_div & (|op1) & (|op2);

assign div_port.start    = in_valid & div_iter;
assign div_port.dividend = op1;
assign div_port.divisor  = op2;

// Zero divisor gives all ones or the dividend, zero dividend gives zero
always_comb begin
    if (div_iter) begin
        div_res = (cmd == CMD_REMU) ? div_port.remainder : div_port.quotient;
    end else if ((|op2) | (cmd == CMD_REMU)) begin
        div_res = op1;
    end else begin
        div_res = '1;
    end
end

assign in_ready = div_port.start ? div_port.done : 1'b1;
assign busy     = in_valid & ~in_ready;

//----------------------------------------------------------------------
// Result select
//----------------------------------------------------------------------
always_comb begin
    case (cmd)
        CMD_AND:  result = op1 & op2;
        CMD_OR:   result = op1 | op2;
        CMD_XOR:  result = op1 ^ op2;
        CMD_ADD,
        CMD_SUB:  result = sum_res[`IALU_XLEN-1:0];
        CMD_LT,
        CMD_LTU,
        CMD_EQ,
        CMD_NE,
        CMD_GE,
        CMD_GEU:  result = {{(`IALU_XLEN-1){1'b0}}, cmp};
        CMD_SLL,
        CMD_SRL,
        CMD_SRA:  result = shft_res;
        CMD_DIVU,
        CMD_REMU: result = div_res;
        default:  result = '0;
    endcase
end

endmodule

// ==== logic/serial_divider.sv ====
// Bit-serial restoring divider for unsigned operands, one quotient bit per cycle.
// Loads on the first edge with start high, iterates XLEN edges, then pulses done.
// Dropping start at any time sends it back to IDLE.

`include "ialu_cfg.svh"

module serial_divider
    import ialu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    div_if.divider   div_port
);

div_state_e             state;
logic [`IALU_CNT_W-1:0] cnt;        // Iterations left minus one
logic                   done_q;
logic [`IALU_XLEN-1:0]  rem_q;      // Partial remainder
logic [`IALU_XLEN-1:0]  quo_q;      // Dividend shifts out on top, quotient in at bottom
logic [`IALU_XLEN-1:0]  dvs_q;
logic [`IALU_XLEN:0]    partial;
logic [`IALU_XLEN:0]    diff;
logic                   q_bit;
logic                   iter_en;

//----------------------------------------------------------------------
// One restoring step
//----------------------------------------------------------------------
assign partial = {rem_q, quo_q[`IALU_XLEN-1]};
assign diff    = partial - {1'b0, dvs_q};
assign q_bit   = ~diff[`IALU_XLEN];                 // No borrow, divisor fits
assign iter_en = (state == ITER) & ~done_q;

//----------------------------------------------------------------------
// Control FSM
//----------------------------------------------------------------------
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        state  <= IDLE;
        cnt    <= '0;
        done_q <= 1'b0;
    end else if (!div_port.start) begin
        state  <= IDLE;                             // Abandoned by requester
        done_q <= 1'b0;
    end else begin
        case (state)
            IDLE: begin
                state <= ITER;
                cnt   <= `IALU_CNT_W'(`IALU_XLEN - 1);
            end
            ITER: begin
                if (done_q) begin
                    state  <= IDLE;
                    done_q <= 1'b0;
                end else if (cnt == '0) begin
                    done_q <= 1'b1;                 // Last iteration edge
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end
            default: state <= IDLE;
        endcase
    end
end

//----------------------------------------------------------------------
// Iteration registers
//----------------------------------------------------------------------
always_ff @(posedge clk) begin
    if (div_port.start && (state == IDLE)) begin
        rem_q <= '0;
        quo_q <= div_port.dividend;
        dvs_q <= div_port.divisor;
    end else if (iter_en) begin
        rem_q <= q_bit ? diff[`IALU_XLEN-1:0] : partial[`IALU_XLEN-1:0];
        quo_q <= {quo_q[`IALU_XLEN-2:0], q_bit};
    end
end

assign div_port.done      = done_q;
assign div_port.quotient  = quo_q;
assign div_port.remainder = rem_q;

endmodule

// ==== logic/ialu_top.sv ====
// Top level of the integer ALU with plain ports toward the core pipeline.
// Hold in_valid and operands until in_ready; the result is valid in that cycle.

`include "ialu_cfg.svh"

module ialu_top
    import ialu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  logic [`IALU_XLEN-1:0] op1,
    input  logic [`IALU_XLEN-1:0] op2,
    input  ialu_cmd_e             cmd,
    output logic                  in_ready,
    output logic                  busy,
    output logic [`IALU_XLEN-1:0] result,
    output logic                  cmp
);

div_if u_div_if ();     // Control to divider link

alu_core u_alu_core (
    .in_valid (in_valid),
    .op1      (op1),
    .op2      (op2),
    .cmd      (cmd),
    .in_ready (in_ready),
    .busy     (busy),
    .result   (result),
    .cmp      (cmp),
    .div_port (u_div_if.requester)
);

serial_divider u_serial_divider (
    .clk      (clk),
    .rst_n    (rst_n),
    .div_port (u_div_if.divider)
);

endmodule

// ==== sim/ialu_asserts.sv ====
// Concurrent checks on the ALU handshake and the serial divider.
// Bound into ialu_top; the failure count is read by the testbench at the end.

`include "ialu_cfg.svh"

module ialu_asserts
    import ialu_pkg::*;
(
    input logic                   clk,
    input logic                   rst_n,
    input logic                   in_valid,
    input logic                   in_ready,
    input logic                   busy,
    input ialu_cmd_e              cmd,
    input logic [`IALU_XLEN-1:0]  result,
    input logic                   div_done
);

int   fail_cnt;
logic is_div;

initial fail_cnt = 0;

assign is_div = (cmd == CMD_DIVU) || (cmd == CMD_REMU);

//----------------------------------------------------------------------
// Handshake
//----------------------------------------------------------------------
busy_needs_valid: assert property (@(posedge clk) disable iff (!rst_n) busy |-> in_valid)
    else begin
        fail_cnt++;
        $error("busy high without in_valid");
    end

ready_single_cycle: assert property (@(posedge clk) disable iff (!rst_n) !is_div |-> in_ready)
    else begin
        fail_cnt++;
        $error("in_ready low for a non-division command");
    end

result_known: assert property (@(posedge clk) disable iff (!rst_n)
    (in_valid && in_ready) |-> !$isunknown(result))
    else begin
        fail_cnt++;
        $error("result unknown at handshake");
    end

//----------------------------------------------------------------------
// Divider
//----------------------------------------------------------------------
done_pulse: assert property (@(posedge clk) disable iff (!rst_n) div_done |=> !div_done)
    else begin
        fail_cnt++;
        $error("divider done held for two cycles");
    end

endmodule

bind ialu_top ialu_asserts u_ialu_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .busy      (busy),
    .cmd       (cmd),
    .result    (result),
    .div_done  (u_div_if.done)
);

// ==== sim/ialu_tb.sv ====
// Directed testbench for the integer ALU: logic, arithmetic, compares, shifts
// and unsigned division. Every operation waits on in_ready with a bounded loop.

`include "ialu_cfg.svh"

module ialu_tb
    import ialu_pkg::*;
();

localparam int TIMEOUT = 100;   // Cycles allowed per operation

logic                  clk;
logic                  rst_n;
logic                  in_valid;
logic [`IALU_XLEN-1:0] op1;
logic [`IALU_XLEN-1:0] op2;
ialu_cmd_e             cmd;
logic                  in_ready;
logic                  busy;
logic [`IALU_XLEN-1:0] result;
logic                  cmp;

logic [31:0] rng_state;
int          checks;
int          errors;
int          timeouts;
int          assert_fails;

ialu_top u_ialu_top (.*);

initial clk = 1'b0;
always #5 clk = ~clk;

function logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);  // xorshift32
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

function automatic logic expected_cmp(input ialu_cmd_e c, input logic [`IALU_XLEN-1:0] a,
                                      input logic [`IALU_XLEN-1:0] b);
    case (c)
        CMD_LT:  return $signed(a) < $signed(b);
        CMD_LTU: return a < b;
        CMD_EQ:  return a == b;
        CMD_NE:  return a != b;
        CMD_GE:  return $signed(a) >= $signed(b);
        default: return a >= b;
    endcase
endfunction

// One bit position per step, SRA copies the sign bit into the top
function automatic logic [`IALU_XLEN-1:0] shift_model(input ialu_cmd_e c,
                                                      input logic [`IALU_XLEN-1:0] a,
                                                      input int amount);
    logic [`IALU_XLEN-1:0] v;
    v = a;
    for (int i = 0; i < amount; i++) begin
        case (c)
            CMD_SLL: v = {v[`IALU_XLEN-2:0], 1'b0};
            CMD_SRL: v = {1'b0, v[`IALU_XLEN-1:1]};
            default: v = {v[`IALU_XLEN-1], v[`IALU_XLEN-1:1]};
        endcase
    end
    return v;
endfunction

task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
        errors++;
        $display("FAIL t=%0t %s: got %h, expected %h", $time, what, got, exp);
    end
endtask

//----------------------------------------------------------------------
// One operation, held until in_ready, sampled at the falling edge
//----------------------------------------------------------------------
task automatic run_op(input ialu_cmd_e c, input logic [`IALU_XLEN-1:0] a,
                      input logic [`IALU_XLEN-1:0] b, output logic [`IALU_XLEN-1:0] res,
                      output logic cbit, output int waits);
    bit seen;
    in_valid = 1'b1;
    cmd      = c;
    op1      = a;
    op2      = b;
    seen     = 1'b0;
    waits    = 0;
    while (!seen && waits < TIMEOUT) begin
        @(negedge clk);
        if (in_ready) seen = 1'b1;
        else waits++;
    end
    res  = result;
    cbit = cmp;
    if (!seen) begin
        timeouts++;
        $display("Timeout at %0t: the unit never became ready for %s", $time, c.name());
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
endtask

task automatic run_and_check(input ialu_cmd_e c, input logic [`IALU_XLEN-1:0] a,
                             input logic [`IALU_XLEN-1:0] b, input logic [`IALU_XLEN-1:0] exp,
                             input bit instant);
    logic [`IALU_XLEN-1:0] res;
    logic                  cbit;
    int                    waits;
    run_op(c, a, b, res, cbit, waits);
    check_value({c.name(), " result"}, res, exp);
    if (instant) check_value({c.name(), " latency"}, waits, 0);
endtask

//----------------------------------------------------------------------
// Tests
//----------------------------------------------------------------------
task automatic test_logic_arith();
    ialu_cmd_e             ops [5] = '{CMD_AND, CMD_OR, CMD_XOR, CMD_ADD, CMD_SUB};
    logic [`IALU_XLEN-1:0] a;
    logic [`IALU_XLEN-1:0] b;
    logic [`IALU_XLEN-1:0] exp;
    logic [`IALU_XLEN-1:0] res;
    logic                  cbit;
    int                    waits;
    for (int i = 0; i < 20; i++) begin
        a = next_rand();
        b = next_rand();
        for (int k = 0; k < 5; k++) begin
            case (ops[k])
                CMD_AND: exp = a & b;
                CMD_OR:  exp = a | b;
                CMD_XOR: exp = a ^ b;
                CMD_ADD: exp = a + b;
                default: exp = a - b;
            endcase
            run_op(ops[k], a, b, res, cbit, waits);
            check_value({ops[k].name(), " result"}, res, exp);
            check_value({ops[k].name(), " latency"}, waits, 0);
            check_value({ops[k].name(), " cmp"}, 32'(cbit), 0);
        end
    end
endtask

task automatic test_compares();
    logic [`IALU_XLEN-1:0] pa [12] = '{32'h7fffffff, 32'h80000000, 32'h80000000, 32'h12345678,
                                       32'h80000000, 32'h00000000, 0, 0, 0, 0, 0, 0};
    logic [`IALU_XLEN-1:0] pb [12] = '{32'hffffffff, 32'h00000001, 32'h7fffffff, 32'h12345678,
                                       32'h80000000, 32'h80000000, 0, 0, 0, 0, 0, 0};
    ialu_cmd_e             c;
    logic [`IALU_XLEN-1:0] res;
    logic                  cbit;
    logic                  exp;
    int                    waits;
    for (int i = 6; i < 12; i++) begin
        pa[i] = next_rand();
        pb[i] = next_rand();
    end
    for (int i = 0; i < 12; i++) begin
        for (int k = CMD_LT; k <= CMD_GEU; k++) begin
            c   = ialu_cmd_e'(k);
            exp = expected_cmp(c, pa[i], pb[i]);
            run_op(c, pa[i], pb[i], res, cbit, waits);
            check_value({c.name(), " result"}, res, 32'(exp));
            check_value({c.name(), " cmp"}, 32'(cbit), 32'(exp));
        end
    end
endtask

task automatic test_shifts();
    logic [`IALU_XLEN-1:0] a;
    logic [`IALU_XLEN-1:0] b;
    int                    sh;
    for (int i = 0; i < 11; i++) begin
        a  = (i == 0) ? 32'h80000000 : next_rand();
        b  = (i == 0) ? 32'hffffffff : next_rand();   // Upper bits of op2 ignored
        sh = int'(b[`IALU_SHAMT_W-1:0]);
        run_and_check(CMD_SLL, a, b, shift_model(CMD_SLL, a, sh), 1'b1);
        run_and_check(CMD_SRL, a, b, shift_model(CMD_SRL, a, sh), 1'b1);
        run_and_check(CMD_SRA, a, b, shift_model(CMD_SRA, a, sh), 1'b1);
    end
endtask

task automatic test_divide();
    logic [`IALU_XLEN-1:0] a;
    logic [`IALU_XLEN-1:0] b;
    for (int i = 0; i < 10; i++) begin
        a = next_rand() | 32'h1;
        b = (next_rand() >> (next_rand() % 32)) | 32'h1;   // Spread of divisor sizes
        run_and_check(CMD_DIVU, a, b, a / b, 1'b0);
        run_and_check(CMD_REMU, a, b, a % b, 1'b0);
    end
    run_and_check(CMD_DIVU, 32'hffffffff, 32'h1, 32'hffffffff, 1'b0);
    run_and_check(CMD_REMU, 32'h5, 32'h7, 32'h5, 1'b0);
endtask

task automatic test_divide_zero();
    logic [`IALU_XLEN-1:0] a;
    a = next_rand() | 32'h1;
    run_and_check(CMD_DIVU, a, 0, 32'hffffffff, 1'b1);   // Zero divisor
    run_and_check(CMD_REMU, a, 0, a, 1'b1);
    run_and_check(CMD_DIVU, 0, a, 0, 1'b1);              // Zero dividend
    run_and_check(CMD_REMU, 0, a, 0, 1'b1);
    run_and_check(CMD_DIVU, 0, 0, 32'hffffffff, 1'b1);
endtask

task automatic test_abandon();
    logic [`IALU_XLEN-1:0] a;
    logic [`IALU_XLEN-1:0] b;
    in_valid = 1'b1;
    cmd      = CMD_DIVU;
    op1      = next_rand() | 32'h1;
    op2      = (next_rand() >> 8) | 32'h1;
    for (int i = 0; i < 10; i++) begin
        @(negedge clk);
        check_value("busy during division", 32'(busy), 1);
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;                                 // Abandon mid-way
    @(posedge clk);
    #1;
    a = next_rand();
    b = (next_rand() >> 4) | 32'h1;
    run_and_check(CMD_DIVU, a, b, a / b, 1'b0);
    run_and_check(CMD_REMU, a, b, a % b, 1'b0);
endtask

initial begin
    rng_state = 32'd88;
    checks    = 0;
    errors    = 0;
    timeouts  = 0;
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    op1       = '0;
    op2       = '0;
    cmd       = CMD_AND;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_logic_arith();
    test_compares();
    test_shifts();
    test_divide();
    test_divide_zero();
    test_abandon();
    assert_fails = u_ialu_top.u_ialu_asserts.fail_cnt;
    $display("Checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
             checks, errors, timeouts, assert_fails);
    if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
        $display("Result: PASSED");
    end else begin
        $display("Result: FAILED");
    end
    $finish;
end

endmodule

// ==== ialu.f ====
+incdir+logic
logic/ialu_pkg.sv
logic/div_if.sv
logic/alu_core.sv
logic/serial_divider.sv
logic/ialu_top.sv
sim/ialu_asserts.sv
sim/ialu_tb.sv

// ==== Makefile ====
# Verilator build and run for the integer ALU testbench

VERILATOR ?= verilator
TOP       := ialu_tb
FILELIST  := ialu.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --assert --timing -Wno-fatal -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
RUN_FLAGS := +verilator+error+limit+100
LOG       := sim.log
PASS_MSG  := Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
